/* common/lcd_pkg.sv */
// Constants fit a 480x272 RGB666 panel in sync-plus-DE mode and all counters are cnt_w bits
package lcd_pkg;

    // Horizontal timing in dots
    localparam int h_active = 480;
    localparam int h_back = 30;
    localparam int h_front = 50;
    localparam int h_total = h_back + h_active + h_front;

    // Vertical timing in lines
    localparam int v_active = 272;
    localparam int v_back = 5;
    localparam int v_front = 20;
    localparam int v_total = v_back + v_active + v_front;

    // Sync pulses sit at the start of the back porch
    localparam int hsync_len = 4;
    localparam int vsync_len = 2;

    // Colour bar geometry
    localparam int bar_width = 60;
    localparam int bar_count = 8;
    localparam int bar_idx_w = $clog2(bar_count);

    // Pixel FIFO depth doubles as the initial credit count
    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

    localparam int cnt_w = 10;
    localparam int scroll_w = 3;

    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
    } rgb666_t;

    typedef struct packed {
        logic de;
        logic hsync_n;
        logic vsync_n;
    } scan_t;

    localparam logic [5:0] chan_max = 6'd63;

    // Bar order from the left edge before scrolling
    localparam rgb666_t bar_colors [bar_count] = '{
        '{r: 6'd0,    g: 6'd0,    b: 6'd0},
        '{r: chan_max, g: 6'd0,    b: 6'd0},
        '{r: 6'd0,    g: chan_max, b: 6'd0},
        '{r: 6'd0,    g: 6'd0,    b: chan_max},
        '{r: chan_max, g: chan_max, b: 6'd0},
        '{r: 6'd0,    g: chan_max, b: chan_max},
        '{r: chan_max, g: 6'd0,    b: chan_max},
        '{r: chan_max, g: chan_max, b: chan_max}
    };

endpackage

/* hdl/lcd_timing.sv */
// Counters free-run from reset with no external sync input and scan lags them by one clock
`timescale 1ns/10ps

module lcd_timing import lcd_pkg::*; (
    input  logic  lcd_clk,
    input  logic  rst_n,
    output scan_t scan
);

    logic [cnt_w-1:0] h_cnt;
    logic [cnt_w-1:0] v_cnt;
    logic             h_last;
    logic             v_last;
    logic             h_act;
    logic             v_act;
    scan_t            scan_next;

    assign h_last = (h_cnt == cnt_w'(h_total - 1));
    assign v_last = (v_cnt == cnt_w'(v_total - 1));

    // Dot counter wraps at h_total and steps the line counter
    always_ff @(posedge lcd_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // Active window starts right after the back porch
    assign h_act = (h_cnt >= cnt_w'(h_back)) && (h_cnt < cnt_w'(h_back + h_active));
    assign v_act = (v_cnt >= cnt_w'(v_back)) && (v_cnt < cnt_w'(v_back + v_active));

    always_comb begin
        scan_next.de = h_act && v_act;
        scan_next.hsync_n = !(h_cnt < cnt_w'(hsync_len));
        scan_next.vsync_n = !(v_cnt < cnt_w'(vsync_len));
    end

    always_ff @(posedge lcd_clk or negedge rst_n) begin
        if (!rst_n) begin
            scan.de <= 1'b0;
            scan.hsync_n <= 1'b1;
            scan.vsync_n <= 1'b1;
        end else begin
            scan <= scan_next;
        end
    end

endmodule

/* hdl/bar_pattern_gen.sv */
// Runs ahead of the scan by at most fifo_depth pixels and relies on credit_return for pacing
`timescale 1ns/10ps

module bar_pattern_gen import lcd_pkg::*; (
    input  logic                lcd_clk,
    input  logic                rst_n,
    input  logic [scroll_w-1:0] scroll_step,
    input  logic                credit_return,
    output logic                push,
    output rgb666_t             push_data
);

    logic [cnt_w-1:0]      x;
    logic [cnt_w-1:0]      y;
    logic [cnt_w-1:0]      offset;
    logic [scroll_w-1:0]   step_q;
    logic [fifo_cnt_w-1:0] credits;
    logic [cnt_w:0]        x_sum;
    logic [cnt_w-1:0]      x_wrap;
    logic [cnt_w:0]        offset_sum;
    logic [cnt_w-1:0]      offset_next;
    logic [bar_idx_w-1:0]  bar_idx;
    logic                  x_last;
    logic                  y_last;

    assign push = (credits != '0);

    assign x_last = (x == cnt_w'(h_active - 1));
    assign y_last = (y == cnt_w'(v_active - 1));

    // Scrolled column folded back into the active width
    assign x_sum = {1'b0, x} + {1'b0, offset};
    assign x_wrap = (x_sum >= (cnt_w + 1)'(h_active)) ? cnt_w'(x_sum - (cnt_w + 1)'(h_active))
                                                      : cnt_w'(x_sum);
    assign bar_idx = bar_idx_w'(x_wrap / cnt_w'(bar_width));
    assign push_data = bar_colors[bar_idx];

    // Next frame offset modulo h_active
    assign offset_sum = {1'b0, offset} + (cnt_w + 1)'(step_q);
    assign offset_next = (offset_sum >= (cnt_w + 1)'(h_active))
                       ? cnt_w'(offset_sum - (cnt_w + 1)'(h_active))
                       : cnt_w'(offset_sum);

    always_ff @(posedge lcd_clk or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
            offset <= '0;
            step_q <= '0;
        end else if (push) begin
            // Step is taken with the first pixel and applied once the frame is done
            if (x == '0 && y == '0) begin
                step_q <= scroll_step;
            end
            if (x_last) begin
                x <= '0;
                if (y_last) begin
                    y <= '0;
                    offset <= offset_next;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // One credit per free FIFO slot
    always_ff @(posedge lcd_clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= fifo_cnt_w'(fifo_depth);
        end else begin
            case ({push, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* hdl/pixel_fifo.sv */
// Pushes when full and pops when empty are dropped so callers must track occupancy themselves
`timescale 1ns/10ps

module pixel_fifo import lcd_pkg::*; #(
    parameter type payload_t = rgb666_t
) (
    input  logic     lcd_clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty
);

    payload_t              mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;
    logic                  full;
    logic                  wr_en;
    logic                  rd_en;

    function automatic logic [fifo_ptr_w-1:0] next_ptr(input logic [fifo_ptr_w-1:0] ptr);
        next_ptr = (ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == fifo_cnt_w'(fifo_depth));
    assign empty = (count == '0);
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    // Oldest entry is visible without a read cycle
    assign head = mem[rd_ptr];

    always_ff @(posedge lcd_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge lcd_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/lcd_scanout.sv */
// Outputs trail scan by one clock and an underflow shows black and latches until reset
`timescale 1ns/10ps

module lcd_scanout import lcd_pkg::*; (
    input  logic    lcd_clk,
    input  logic    rst_n,
    input  scan_t   scan,
    input  rgb666_t head,
    input  logic    empty,
    output logic    pop,
    output logic    credit_return,
    output logic    lcd_de,
    output logic    lcd_hsync_n,
    output logic    lcd_vsync_n,
    output rgb666_t lcd_rgb,
    output logic    underflow
);

    // One pixel per active dot while the FIFO has data
    assign pop = scan.de && !empty;

    // Each pop frees a slot for the generator
    assign credit_return = pop;

    always_ff @(posedge lcd_clk or negedge rst_n) begin
        if (!rst_n) begin
            lcd_de <= 1'b0;
            lcd_hsync_n <= 1'b1;
            lcd_vsync_n <= 1'b1;
            lcd_rgb <= '0;
        end else begin
            lcd_de <= scan.de;
            lcd_hsync_n <= scan.hsync_n;
            lcd_vsync_n <= scan.vsync_n;
            // Blanking and missing pixels both drive black
            lcd_rgb <= pop ? head : '0;
        end
    end

    always_ff @(posedge lcd_clk or negedge rst_n) begin
        if (!rst_n) begin
            underflow <= 1'b0;
        end else if (scan.de && empty) begin
            underflow <= 1'b1;
        end
    end

endmodule

/* hdl/lcd_top.sv */
// Timing is free-running from reset and scroll_step is sampled once per frame by the generator
`timescale 1ns/10ps

module lcd_top import lcd_pkg::*; (
    input  logic                lcd_clk,
    input  logic                rst_n,
    input  logic [scroll_w-1:0] scroll_step,
    output logic                lcd_de,
    output logic                lcd_hsync_n,
    output logic                lcd_vsync_n,
    output rgb666_t             lcd_rgb,
    output logic                underflow
);

    scan_t   scan;
    logic    push;
    rgb666_t push_data;
    logic    pop;
    rgb666_t head;
    logic    empty;
    logic    credit_return;

    lcd_timing u_timing (
        .lcd_clk (lcd_clk),
        .rst_n   (rst_n),
        .scan    (scan)
    );

    bar_pattern_gen u_pattern (
        .lcd_clk       (lcd_clk),
        .rst_n         (rst_n),
        .scroll_step   (scroll_step),
        .credit_return (credit_return),
        .push          (push),
        .push_data     (push_data)
    );

    pixel_fifo #(
        .payload_t (rgb666_t)
    ) u_fifo (
        .lcd_clk   (lcd_clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .empty     (empty)
    );

    lcd_scanout u_scanout (
        .lcd_clk       (lcd_clk),
        .rst_n         (rst_n),
        .scan          (scan),
        .head          (head),
        .empty         (empty),
        .pop           (pop),
        .credit_return (credit_return),
        .lcd_de        (lcd_de),
        .lcd_hsync_n   (lcd_hsync_n),
        .lcd_vsync_n   (lcd_vsync_n),
        .lcd_rgb       (lcd_rgb),
        .underflow     (underflow)
    );

endmodule

/* dv/lcd_tb.sv */
// Runs four full frames of h_total*v_total clocks each, so a run takes several hundred thousand cycles
`timescale 1ns/10ps

module lcd_tb import lcd_pkg::*; ();

    localparam int frame_clks = h_total * v_total;
    localparam int wait_limit = 2 * frame_clks;
    localparam int reset_cycles = 10;
    localparam int frames_to_run = 4;
    localparam int scroll_line = 100;

    logic                lcd_clk = 1'b0;
    logic                rst_n;
    logic [scroll_w-1:0] scroll_step;
    logic                lcd_de;
    logic                lcd_hsync_n;
    logic                lcd_vsync_n;
    rgb666_t             lcd_rgb;
    logic                underflow;

    logic [31:0] lcg_state;
    int          checks [1:6];
    int          errors [1:6];
    int          cyc;
    int          last_vs_fall;
    int          last_hs_fall;
    int          last_hs_rise;
    int          line_cnt;
    int          x_pos;
    int          offset;
    int          frame_step;
    int          frames_done;
    int          total_errors;
    int          failed_tests;
    logic        prev_de;
    logic        prev_hs;
    logic        prev_vs;
    bit          timed_out;

    lcd_top u_dut (
        .lcd_clk     (lcd_clk),
        .rst_n       (rst_n),
        .scroll_step (scroll_step),
        .lcd_de      (lcd_de),
        .lcd_hsync_n (lcd_hsync_n),
        .lcd_vsync_n (lcd_vsync_n),
        .lcd_rgb     (lcd_rgb),
        .underflow   (underflow)
    );

    always #5 lcd_clk = ~lcd_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        lcg_next = state * 32'd1103515245 + 32'd12345;
    endfunction

    // Bars left to right before any scroll
    function automatic logic [17:0] bar_color(input int idx);
        logic [5:0] full;
        full = 6'd63;
        case (idx)
            1: bar_color = {full, 6'd0, 6'd0};
            2: bar_color = {6'd0, full, 6'd0};
            3: bar_color = {6'd0, 6'd0, full};
            4: bar_color = {full, full, 6'd0};
            5: bar_color = {6'd0, full, full};
            6: bar_color = {full, 6'd0, full};
            7: bar_color = {full, full, full};
            default: bar_color = {6'd0, 6'd0, 6'd0};
        endcase
    endfunction

    function automatic logic [17:0] expected_pixel(input int x, input int off);
        expected_pixel = bar_color(((x + off) % h_active) / bar_width);
    endfunction

    task automatic report_error(input int test_id, input string name, input int expected,
                                input int actual);
        errors[test_id]++;
        $display("error at %0d ns: %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
    endtask

    task automatic check_reset_outputs();
        checks[1] += 5;
        if (lcd_de !== 1'b0)
            report_error(1, "lcd_de", 0, int'(lcd_de));
        if (lcd_hsync_n !== 1'b1)
            report_error(1, "lcd_hsync_n", 1, int'(lcd_hsync_n));
        if (lcd_vsync_n !== 1'b1)
            report_error(1, "lcd_vsync_n", 1, int'(lcd_vsync_n));
        if (lcd_rgb !== '0)
            report_error(1, "lcd_rgb", 0, int'(lcd_rgb));
        if (underflow !== 1'b0)
            report_error(1, "underflow", 0, int'(underflow));
    endtask

    // Reference model called once per falling edge while outputs are stable
    task automatic observe_cycle();
        logic [17:0] exp_rgb;
        int          pix_test;
        cyc++;
        checks[6]++;
        if (underflow !== 1'b0)
            report_error(6, "underflow", 0, int'(underflow));
        // New frame on the vsync fall
        if (prev_vs && !lcd_vsync_n) begin
            if (last_vs_fall >= 0) begin
                checks[2] += 2;
                if (cyc - last_vs_fall != frame_clks)
                    report_error(2, "lcd_vsync_n period", frame_clks, cyc - last_vs_fall);
                if (line_cnt != v_active)
                    report_error(2, "de lines per frame", v_active, line_cnt);
                offset = (offset + frame_step) % h_active;
                frames_done++;
            end
            last_vs_fall = cyc;
            line_cnt = 0;
        end
        if (!prev_vs && lcd_vsync_n) begin
            checks[3]++;
            if (cyc - last_vs_fall != vsync_len * h_total)
                report_error(3, "lcd_vsync_n low clocks", vsync_len * h_total, cyc - last_vs_fall);
        end
        if (prev_hs && !lcd_hsync_n)
            last_hs_fall = cyc;
        if (!prev_hs && lcd_hsync_n) begin
            last_hs_rise = cyc;
            checks[3]++;
            if (cyc - last_hs_fall != hsync_len)
                report_error(3, "lcd_hsync_n low clocks", hsync_len, cyc - last_hs_fall);
        end
        if (!prev_de && lcd_de) begin
            checks[3] += 2;
            if (cyc - last_hs_fall != h_back)
                report_error(3, "hsync fall to de rise", h_back, cyc - last_hs_fall);
            if (cyc - last_hs_rise != h_back - hsync_len)
                report_error(3, "hsync rise to de rise", h_back - hsync_len, cyc - last_hs_rise);
            if (line_cnt == 0) begin
                checks[3]++;
                if (cyc - last_vs_fall != v_back * h_total + h_back)
                    report_error(3, "vsync fall to first de", v_back * h_total + h_back,
                                 cyc - last_vs_fall);
                // Step in force at the first pixel sets the next frame's offset
                frame_step = int'(scroll_step);
            end
            x_pos = 0;
        end
        if (prev_de && !lcd_de) begin
            checks[2]++;
            if (x_pos != h_active)
                report_error(2, "de clocks per line", h_active, x_pos);
            line_cnt++;
            if (line_cnt == scroll_line) begin
                lcg_state = lcg_next(lcg_state);
                scroll_step = lcg_state[16 +: scroll_w];
            end
        end
        if (lcd_de) begin
            exp_rgb = expected_pixel(x_pos, offset);
            // Column 0 and each scrolled bar edge track the frame offset
            pix_test = (x_pos == 0 || (x_pos + offset) % bar_width == 0) ? 5 : 4;
            checks[pix_test]++;
            if (lcd_rgb !== exp_rgb)
                report_error(pix_test, "lcd_rgb", int'(exp_rgb), int'(lcd_rgb));
            x_pos++;
        end else begin
            checks[4]++;
            if (lcd_rgb !== '0)
                report_error(4, "lcd_rgb in blanking", 0, int'(lcd_rgb));
        end
        prev_de = lcd_de;
        prev_hs = lcd_hsync_n;
        prev_vs = lcd_vsync_n;
    endtask

    task automatic wait_frame_start(output bit expired);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        expired = 1'b0;
        while (!seen && !expired) begin
            @(negedge lcd_clk);
            seen = prev_vs && !lcd_vsync_n;
            observe_cycle();
            n++;
            if (!seen && n >= wait_limit)
                expired = 1'b1;
        end
        if (expired)
            $display("timeout: lcd_vsync_n did not fall within two frames");
    endtask

    task automatic print_test_line(input int test_id, input string name);
        if (checks[test_id] == 0) begin
            errors[test_id]++;
            $display("test %0d %s made no checks", test_id, name);
        end
        $display("test %0d %s: %0d checks, %0d errors, %s", test_id, name, checks[test_id],
                 errors[test_id], (errors[test_id] == 0) ? "ok" : "failed");
        total_errors += errors[test_id];
        if (errors[test_id] != 0)
            failed_tests++;
    endtask

    initial begin
        int i;
        rst_n = 1'b0;
        lcg_state = 32'd80;
        lcg_state = lcg_next(lcg_state);
        scroll_step = lcg_state[16 +: scroll_w];
        for (i = 1; i <= 6; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
        cyc = 0;
        last_vs_fall = -1;
        last_hs_fall = -1;
        last_hs_rise = -1;
        line_cnt = 0;
        x_pos = 0;
        offset = 0;
        frame_step = 0;
        frames_done = 0;
        total_errors = 0;
        failed_tests = 0;
        prev_de = 1'b0;
        prev_hs = 1'b1;
        prev_vs = 1'b1;

        for (i = 0; i < reset_cycles; i++) begin
            @(negedge lcd_clk);
            check_reset_outputs();
        end
        rst_n = 1'b1;
        @(negedge lcd_clk);
        check_reset_outputs();
        print_test_line(1, "reset values");
        observe_cycle();

        // One extra vsync fall closes the last frame
        timed_out = 1'b0;
        while (frames_done < frames_to_run && !timed_out)
            wait_frame_start(timed_out);

        print_test_line(2, "frame geometry");
        print_test_line(3, "sync placement");
        print_test_line(4, "pixel content");
        print_test_line(5, "scroll");
        print_test_line(6, "flow integrity");
        $display("tests: 6, failed: %0d, errors: %0d, final offset: %0d",
                 failed_tests, total_errors, offset);
        if (timed_out || total_errors != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

/* sources.f */
common/lcd_pkg.sv
hdl/lcd_timing.sv
hdl/bar_pattern_gen.sv
hdl/pixel_fifo.sv
hdl/lcd_scanout.sv
hdl/lcd_top.sv
dv/lcd_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the LCD testbench with Verilator from the project root
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sources.f --top-module lcd_tb -o lcd_tb

./obj_dir/lcd_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
